// File: design/lockstep_pkg.sv
// Lockstep checker package
// Shared constants, bus types and core state encoding

package lockstep_pkg;

  //////////////////////////////////////////////////////////////
  // Lockstep timing
  //////////////////////////////////////////////////////////////

  // Cycles by which the shadow core trails the main core
  localparam int unsigned LOCKSTEP_OFFSET = 2;
  // One extra cycle for the shadow output register
  localparam int unsigned OUTPUTS_OFFSET  = LOCKSTEP_OFFSET + 1;
  localparam int unsigned OFFSET_CNT_W    = $clog2(LOCKSTEP_OFFSET + 1);

  //////////////////////////////////////////////////////////////
  // Bus geometry
  //////////////////////////////////////////////////////////////

  localparam int unsigned DATA_W = 32;
  localparam int unsigned ADDR_W = 32;
  localparam int unsigned IRQ_W  = 4;

  localparam logic [31:0] BOOT_ADDR = 32'h0000_0080;
  localparam int unsigned ADDR_STEP = 4;

  typedef logic [DATA_W-1:0]       data_t;
  typedef logic [ADDR_W-1:0]       addr_t;
  typedef logic [IRQ_W-1:0]        irq_t;
  typedef logic [OFFSET_CNT_W-1:0] offset_cnt_t;

  //////////////////////////////////////////////////////////////
  // Core ports
  //////////////////////////////////////////////////////////////

  // Everything the core samples
  typedef struct packed {
    logic  bus_gnt;
    logic  bus_rvalid;
    data_t bus_rdata;
    logic  bus_err;
    irq_t  irq;
    logic  fetch_enable;
  } core_in_t;

  // Everything the core drives, 67 bits
  typedef struct packed {
    logic  bus_req;
    addr_t bus_addr;
    data_t bus_wdata;
    logic  irq_pending;
    logic  core_busy;
  } core_out_t;

  // Fetch FSM
  typedef enum logic [1:0] {
    CORE_IDLE = 2'd0,
    CORE_REQ  = 2'd1,
    CORE_WAIT = 2'd2
  } core_state_e;

endpackage

// File: design/lockstep_reset_seq.sv
// Lockstep reset sequencer
// Keeps the shadow core in reset for the lockstep offset, then enables comparison

`timescale 1ns/1ns

module lockstep_reset_seq (
  input  logic clk_i,
  input  logic rst_ni,
  output logic shadow_rst_no,
  output logic cmp_en_o
);

  lockstep_pkg::offset_cnt_t cnt_d, cnt_q;
  logic                      release_d, release_q;
  logic                      cmp_en_q;

  // Counter stops once the offset has elapsed
  assign release_d = (cnt_q == lockstep_pkg::offset_cnt_t'(lockstep_pkg::LOCKSTEP_OFFSET - 1));
  assign cnt_d     = release_d ? cnt_q : cnt_q + 1'b1;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      cnt_q     <= '0;
      release_q <= 1'b0;
      cmp_en_q  <= 1'b0;
    end else begin
      cnt_q     <= cnt_d;
      release_q <= release_d;
      // Comparison starts one cycle after the shadow leaves reset
      cmp_en_q  <= release_q;
    end
  end

  // Shadow reset follows system reset immediately on assertion
  assign shadow_rst_no = release_q & rst_ni;
  assign cmp_en_o      = cmp_en_q;

endmodule

// File: design/lockstep_delay_line.sv
// Fixed-latency delay line
// Shift register of Depth stages, cleared to zero on reset

`timescale 1ns/1ns

module lockstep_delay_line #(
  parameter int unsigned Depth = 2,
  parameter int unsigned Width = 8
) (
  input  logic             clk_i,
  input  logic             rst_ni,
  input  logic [Width-1:0] data_i,
  output logic [Width-1:0] data_o
);

  // Stage Depth-1 takes new data, stage 0 is the oldest
  logic [Depth-1:0][Width-1:0] stage_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      stage_q <= '0;
    end else begin
      for (int unsigned i = 0; i + 1 < Depth; i++) begin
        stage_q[i] <= stage_q[i+1];
      end
      stage_q[Depth-1] <= data_i;
    end
  end

  assign data_o = stage_q[0];

endmodule

// File: design/lockstep_shadow_core.sv
// Fetch-and-accumulate core
// Fetches words from a linear address stream and sums them; all outputs come from flops

`timescale 1ns/1ns

module lockstep_shadow_core (
  input  logic                    clk_i,
  input  logic                    rst_ni,
  input  lockstep_pkg::core_in_t  core_in_i,
  output lockstep_pkg::core_out_t core_out_o,
  output logic                    alert_bus_o
);

  lockstep_pkg::core_state_e state_d, state_q;
  lockstep_pkg::addr_t       addr_d, addr_q;
  lockstep_pkg::data_t       acc_d, acc_q;
  logic                      irq_pending_q;
  logic                      alert_bus_q;
  logic                      rsp_accept;

  //////////////////////////////////////////////////////////////
  // Fetch FSM
  //////////////////////////////////////////////////////////////

  assign rsp_accept = (state_q == lockstep_pkg::CORE_WAIT) & core_in_i.bus_rvalid;

  always_comb begin
    state_d = state_q;
    addr_d  = addr_q;
    acc_d   = acc_q;

    case (state_q)
      lockstep_pkg::CORE_IDLE: begin
        if (core_in_i.fetch_enable) begin
          state_d = lockstep_pkg::CORE_REQ;
        end
      end
      lockstep_pkg::CORE_REQ: begin
        // Request held until the bus grants it
        if (core_in_i.bus_gnt) begin
          state_d = lockstep_pkg::CORE_WAIT;
        end
      end
      lockstep_pkg::CORE_WAIT: begin
        if (rsp_accept) begin
          acc_d   = acc_q + core_in_i.bus_rdata;
          addr_d  = addr_q + lockstep_pkg::addr_t'(lockstep_pkg::ADDR_STEP);
          state_d = lockstep_pkg::CORE_REQ;
        end
      end
      default: begin
        state_d = lockstep_pkg::CORE_IDLE;
      end
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q       <= lockstep_pkg::CORE_IDLE;
      addr_q        <= lockstep_pkg::BOOT_ADDR;
      acc_q         <= '0;
      irq_pending_q <= 1'b0;
      alert_bus_q   <= 1'b0;
    end else begin
      state_q       <= state_d;
      addr_q        <= addr_d;
      acc_q         <= acc_d;
      irq_pending_q <= |core_in_i.irq;
      // Any error response raises a single-cycle alert
      alert_bus_q   <= core_in_i.bus_rvalid & core_in_i.bus_err;
    end
  end

  //////////////////////////////////////////////////////////////
  // Outputs
  //////////////////////////////////////////////////////////////

  assign core_out_o.bus_req     = (state_q == lockstep_pkg::CORE_REQ);
  assign core_out_o.bus_addr    = addr_q;
  assign core_out_o.bus_wdata   = acc_q;
  assign core_out_o.irq_pending = irq_pending_q;
  assign core_out_o.core_busy   = (state_q != lockstep_pkg::CORE_IDLE);

  assign alert_bus_o = alert_bus_q;

endmodule

// File: design/lockstep_compare.sv
// Lockstep comparator
// Registers the shadow outputs and flags any difference from the delayed main outputs

`timescale 1ns/1ns

module lockstep_compare (
  input  logic                    clk_i,
  input  logic                    rst_ni,
  input  logic                    cmp_en_i,
  input  lockstep_pkg::core_out_t shadow_out_i,
  input  lockstep_pkg::core_out_t main_out_i,
  input  logic                    shadow_alert_bus_i,
  output logic                    alert_major_internal_o,
  output logic                    alert_major_bus_o
);

  lockstep_pkg::core_out_t shadow_out_q;
  logic                    outputs_mismatch;

  // Extra stage lines the shadow up with the main output delay line
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      shadow_out_q <= '0;
    end else begin
      shadow_out_q <= shadow_out_i;
    end
  end

  // Whole-struct compare, every field counts
  assign outputs_mismatch = cmp_en_i & (shadow_out_q != main_out_i);

  assign alert_major_internal_o = outputs_mismatch;
  // Bus errors are seen by both cores, so the shadow alone reports them
  assign alert_major_bus_o      = shadow_alert_bus_i;

endmodule

// File: design/lockstep_top.sv
// Lockstep checker top level
// Runs a delayed shadow core beside the main core and alerts on any output difference

`timescale 1ns/1ns

module lockstep_top (
  input  logic                    clk_i,
  input  logic                    rst_ni,
  input  lockstep_pkg::core_in_t  core_in_i,
  input  lockstep_pkg::core_out_t core_out_i,
  output logic                    alert_major_internal_o,
  output logic                    alert_major_bus_o
);

  logic                    shadow_rst_n;
  logic                    cmp_en;
  lockstep_pkg::core_in_t  shadow_in;
  lockstep_pkg::core_out_t shadow_out;
  lockstep_pkg::core_out_t main_out_dly;
  logic                    shadow_alert_bus;

  //////////////////////////////////////////////////////////////
  // Reset sequencing
  //////////////////////////////////////////////////////////////

  lockstep_reset_seq u_reset_seq (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .shadow_rst_no (shadow_rst_n),
    .cmp_en_o      (cmp_en)
  );

  //////////////////////////////////////////////////////////////
  // Delay lines
  //////////////////////////////////////////////////////////////

  // Shadow sees the main core stimulus LOCKSTEP_OFFSET cycles late
  lockstep_delay_line #(
    .Depth (lockstep_pkg::LOCKSTEP_OFFSET),
    .Width ($bits(lockstep_pkg::core_in_t))
  ) u_in_delay (
    .clk_i  (clk_i),
    .rst_ni (rst_ni),
    .data_i (core_in_i),
    .data_o (shadow_in)
  );

  lockstep_delay_line #(
    .Depth (lockstep_pkg::OUTPUTS_OFFSET),
    .Width ($bits(lockstep_pkg::core_out_t))
  ) u_out_delay (
    .clk_i  (clk_i),
    .rst_ni (rst_ni),
    .data_i (core_out_i),
    .data_o (main_out_dly)
  );

  //////////////////////////////////////////////////////////////
  // Shadow core and comparison
  //////////////////////////////////////////////////////////////

  lockstep_shadow_core u_shadow_core (
    .clk_i       (clk_i),
    .rst_ni      (shadow_rst_n),
    .core_in_i   (shadow_in),
    .core_out_o  (shadow_out),
    .alert_bus_o (shadow_alert_bus)
  );

  lockstep_compare u_compare (
    .clk_i                  (clk_i),
    .rst_ni                 (rst_ni),
    .cmp_en_i               (cmp_en),
    .shadow_out_i           (shadow_out),
    .main_out_i             (main_out_dly),
    .shadow_alert_bus_i     (shadow_alert_bus),
    .alert_major_internal_o (alert_major_internal_o),
    .alert_major_bus_o      (alert_major_bus_o)
  );

endmodule

// File: verification/lockstep_assert.sv
// Lockstep checker assertions
// Checks compare enable timing, mismatch alert latency and bus alert passthrough

`timescale 1ns/1ns

module lockstep_assert (
  input logic                    clk_i,
  input logic                    rst_ni,
  input lockstep_pkg::core_in_t  core_in_i,
  input lockstep_pkg::core_out_t core_out_i,
  input logic                    cmp_en_i,
  input logic                    alert_internal_i,
  input logic                    alert_bus_i
);

  lockstep_pkg::core_out_t ref_out;
  logic                    fault;
  logic                    bus_err_rsp;
  logic [3:0]              edge_cnt;
  int unsigned             err_cnt = 0;

  // Reference core sees the undelayed main stimulus
  lockstep_shadow_core u_ref_core (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .core_in_i   (core_in_i),
    .core_out_o  (ref_out),
    .alert_bus_o ()
  );

  assign fault       = (core_out_i != ref_out);
  assign bus_err_rsp = core_in_i.bus_rvalid & core_in_i.bus_err;

  // Edges seen since reset release, saturating
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      edge_cnt <= '0;
    end else if (edge_cnt != '1) begin
      edge_cnt <= edge_cnt + 1'b1;
    end
  end

  //////////////////////////////////////////////////////////////
  // Properties
  //////////////////////////////////////////////////////////////

  reset_quiet: assert property (@(posedge clk_i)
    !rst_ni |-> (!alert_internal_i && !alert_bus_i))
  else begin
    err_cnt++;
    $error("Alert raised while in reset");
  end

  cmp_en_timing: assert property (@(posedge clk_i) disable iff (!rst_ni)
    cmp_en_i == (edge_cnt >= 4'(lockstep_pkg::LOCKSTEP_OFFSET + 1)))
  else begin
    err_cnt++;
    $error("Compare enable at wrong cycle after reset");
  end

  // Alert follows the fault by the output offset, one alert cycle per fault cycle
  mismatch_latency: assert property (@(posedge clk_i) disable iff (!rst_ni)
    alert_internal_i == ($past(fault, lockstep_pkg::OUTPUTS_OFFSET) && cmp_en_i))
  else begin
    err_cnt++;
    $error("Internal alert does not match delayed fault");
  end

  bus_alert_latency: assert property (@(posedge clk_i) disable iff (!rst_ni)
    cmp_en_i |-> (alert_bus_i == $past(bus_err_rsp, lockstep_pkg::LOCKSTEP_OFFSET + 1)))
  else begin
    err_cnt++;
    $error("Bus alert does not match delayed error response");
  end

endmodule

bind lockstep_top lockstep_assert u_assert (
  .clk_i            (clk_i),
  .rst_ni           (rst_ni),
  .core_in_i        (core_in_i),
  .core_out_i       (core_out_i),
  .cmp_en_i         (cmp_en),
  .alert_internal_i (alert_major_internal_o),
  .alert_bus_i      (alert_major_bus_o)
);

// File: verification/lockstep_tb.sv
// Lockstep checker testbench
// Main core with a random bus responder beside the checker, plus fault injection

`timescale 1ns/1ns

module lockstep_tb;

  localparam logic [31:0] LFSR_SEED  = 32'hc669_70d3;
  localparam logic [31:0] LFSR_TAPS  = 32'h8020_0003;
  localparam int unsigned WAIT_LIMIT = 40;
  localparam int unsigned RUN_LIMIT  = 20000;
  localparam int unsigned SETTLE     = lockstep_pkg::OUTPUTS_OFFSET + 2;

  logic                    clk_i;
  logic                    rst_ni;
  lockstep_pkg::core_in_t  core_in = '0;
  lockstep_pkg::core_out_t main_out;
  lockstep_pkg::core_out_t inj_mask;
  lockstep_pkg::core_out_t dut_out;
  logic                    alert_internal;
  logic                    alert_bus;
  logic                    fetch_en;
  logic                    err_arm;
  logic [31:0]             lfsr = LFSR_SEED;
  logic [1:0]              rsp_phase = '0;
  logic [1:0]              rsp_delay = '0;
  int unsigned             internal_cnt = 0;
  int unsigned             bus_cnt = 0;

  initial clk_i = 1'b0;
  always #2 clk_i = ~clk_i;

  lockstep_shadow_core main_core (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .core_in_i   (core_in),
    .core_out_o  (main_out),
    .alert_bus_o ()
  );

  // Faults only reach the checker, never the main core
  assign dut_out = main_out ^ inj_mask;

  lockstep_top dut0 (
    .clk_i                  (clk_i),
    .rst_ni                 (rst_ni),
    .core_in_i              (core_in),
    .core_out_i             (dut_out),
    .alert_major_internal_o (alert_internal),
    .alert_major_bus_o      (alert_bus)
  );

  //////////////////////////////////////////////////////////////
  // Helpers
  //////////////////////////////////////////////////////////////

  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    if (s[0]) begin
      return (s >> 1) ^ LFSR_TAPS;
    end
    return s >> 1;
  endfunction

  // One LFSR step per bit taken
  function automatic logic [31:0] take_bits(input int unsigned n);
    logic [31:0] v;
    v = '0;
    for (int unsigned i = 0; i < n; i++) begin
      v    = {v[30:0], lfsr[0]};
      lfsr = lfsr_step(lfsr);
    end
    return v;
  endfunction

  // Single flipped bit in one output field
  function automatic lockstep_pkg::core_out_t field_mask(input int unsigned field);
    lockstep_pkg::core_out_t m;
    logic [4:0]              pos;
    m   = '0;
    pos = 5'(take_bits(5));
    case (field)
      0: m.bus_req = 1'b1;
      1: m.bus_addr[pos] = 1'b1;
      2: m.bus_wdata[pos] = 1'b1;
      3: m.irq_pending = 1'b1;
      default: m.core_busy = 1'b1;
    endcase
    return m;
  endfunction

  task automatic report_failure(input string msg);
    $display("%s", msg);
    $display("SOME TESTS FAILED");
    $fatal(1, "Simulation stopped on first error");
  endtask

  task automatic inject_fault(input lockstep_pkg::core_out_t mask, input int unsigned len);
    int unsigned start;
    int unsigned seen;
    start = internal_cnt;
    @(posedge clk_i);
    inj_mask <= mask;
    repeat (len) @(posedge clk_i);
    inj_mask <= '0;
    for (int unsigned i = 0; i < WAIT_LIMIT; i++) begin
      @(posedge clk_i);
      if ((internal_cnt - start) == len && !alert_internal) begin
        break;
      end
    end
    repeat (SETTLE) @(posedge clk_i);
    seen = internal_cnt - start;
    if (seen != len) begin
      report_failure($sformatf("Fail alert_major_internal_o cycles: expected %h got %h",
                               len, seen));
    end
  endtask

  task automatic bus_error_response();
    int unsigned start;
    int unsigned seen;
    logic        sent;
    start = bus_cnt;
    sent  = 1'b0;
    @(posedge clk_i);
    err_arm <= 1'b1;
    for (int unsigned i = 0; i < WAIT_LIMIT && !sent; i++) begin
      @(posedge clk_i);
      sent = core_in.bus_err;
    end
    err_arm <= 1'b0;
    if (!sent) begin
      report_failure("The bus responder never issued an error response");
    end
    for (int unsigned i = 0; i < WAIT_LIMIT; i++) begin
      @(posedge clk_i);
      if ((bus_cnt - start) == 1 && !alert_bus) begin
        break;
      end
    end
    repeat (SETTLE) @(posedge clk_i);
    seen = bus_cnt - start;
    if (seen != 1) begin
      report_failure($sformatf("Fail alert_major_bus_o cycles: expected %h got %h", 1, seen));
    end
  endtask

  //////////////////////////////////////////////////////////////
  // Bus responder and monitors
  //////////////////////////////////////////////////////////////

  always @(posedge clk_i) begin
    if (!rst_ni) begin
      core_in   <= '0;
      rsp_phase <= 2'd0;
      rsp_delay <= 2'd0;
    end else begin
      core_in.bus_gnt      <= 1'b0;
      core_in.bus_rvalid   <= 1'b0;
      core_in.bus_err      <= 1'b0;
      core_in.fetch_enable <= fetch_en;
      core_in.irq          <= lockstep_pkg::irq_t'(take_bits(lockstep_pkg::IRQ_W));
      case (rsp_phase)
        2'd0: begin
          if (main_out.bus_req) begin
            if (rsp_delay == 2'd0) begin
              core_in.bus_gnt <= 1'b1;
              rsp_phase       <= 2'd1;
              rsp_delay       <= 2'(take_bits(2));
            end else begin
              rsp_delay <= rsp_delay - 1'b1;
            end
          end
        end
        2'd1: begin
          if (rsp_delay == 2'd0) begin
            core_in.bus_rvalid <= 1'b1;
            core_in.bus_rdata  <= take_bits(32);
            core_in.bus_err    <= err_arm;
            rsp_phase          <= 2'd0;
            rsp_delay          <= 2'(take_bits(2));
          end else begin
            rsp_delay <= rsp_delay - 1'b1;
          end
        end
        default: rsp_phase <= 2'd0;
      endcase
    end
  end

  always @(posedge clk_i) begin
    if (alert_internal) begin
      internal_cnt <= internal_cnt + 1;
    end
    if (alert_bus) begin
      bus_cnt <= bus_cnt + 1;
    end
  end

  always @(posedge clk_i) begin
    if (dut0.u_assert.err_cnt != 0) begin
      report_failure("An assertion on the lockstep checker failed");
    end
  end

  initial begin
    repeat (RUN_LIMIT) @(posedge clk_i);
    report_failure("Simulation timed out");
  end

  //////////////////////////////////////////////////////////////
  // Stimulus
  //////////////////////////////////////////////////////////////

  initial begin
    rst_ni   = 1'b0;
    inj_mask = '0;
    fetch_en = 1'b0;
    err_arm  = 1'b0;

    // Faults while in reset must stay silent, the last one right before release
    repeat (4) @(posedge clk_i);
    inj_mask <= field_mask(1);
    @(posedge clk_i);
    inj_mask <= '0;
    repeat (4) @(posedge clk_i);
    inj_mask <= field_mask(2);
    @(posedge clk_i);
    rst_ni   <= 1'b1;
    // Earliest fault the comparator can still see
    inj_mask <= field_mask(3);

    // Sweep across the compare enable edge
    for (int unsigned k = 0; k < 6; k++) begin
      @(posedge clk_i);
      inj_mask <= field_mask(k % 5);
      @(posedge clk_i);
      inj_mask <= '0;
    end
    repeat (SETTLE) @(posedge clk_i);

    // Quiet fetching with random data and irqs
    fetch_en <= 1'b1;
    repeat (60) @(posedge clk_i);

    // Single-cycle faults on every field
    for (int unsigned f = 0; f < 5; f++) begin
      inject_fault(field_mask(f), 1);
      inject_fault(field_mask(f), 1);
    end

    // Multi-cycle faults keep several items in flight
    for (int unsigned r = 0; r < 4; r++) begin
      inject_fault(field_mask(take_bits(3) % 5), 2 + (take_bits(3) % 6));
    end

    // Error responses
    for (int unsigned r = 0; r < 3; r++) begin
      bus_error_response();
      repeat (10) @(posedge clk_i);
    end

    repeat (SETTLE) @(posedge clk_i);
    if (dut0.u_assert.err_cnt != 0) begin
      $display("SOME TESTS FAILED");
      $fatal(1, "Assertion failures at end of run");
    end else begin
      $display("ALL TESTS PASSED");
      $finish;
    end
  end

endmodule

// File: sources.f
design/lockstep_pkg.sv
design/lockstep_reset_seq.sv
design/lockstep_delay_line.sv
design/lockstep_shadow_core.sv
design/lockstep_compare.sv
design/lockstep_top.sv
verification/lockstep_assert.sv
verification/lockstep_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Build and run the lockstep checker simulation with Verilator

cd "$(dirname "$0")" || exit 1

BUILD_LOG=build.log
SIM_LOG=sim.log

verilator --binary --timing --assert -j 0 \
  --top-module lockstep_tb -f sources.f -o lockstep_sim > "$BUILD_LOG" 2>&1 \
  || { cat "$BUILD_LOG"; echo "Build failed"; exit 1; }

./obj_dir/lockstep_sim +verilator+error+limit+100 > "$SIM_LOG" 2>&1
cat "$SIM_LOG"

grep -q "SOME TESTS FAILED" "$SIM_LOG" && { echo "Simulation failed"; exit 1; }
grep -q "ALL TESTS PASSED" "$SIM_LOG" \
  || { echo "Simulation ended without a result"; exit 1; }
echo "Simulation passed" && exit 0
